// ==== Bender.yml ====
package:
  name: fetch

sources:
  - files:
      - src/fetch_pkg.sv
      - src/fetch_unit.sv
      - src/icache.sv
      - src/mem_read_port.sv
      - src/fetch_top.sv
  - target: test
    files:
      - verification/fetch_assertions.sv
      - verification/fetch_tb.sv

// ==== flist.f ====
src/fetch_pkg.sv
src/fetch_unit.sv
src/icache.sv
src/mem_read_port.sv
src/fetch_top.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // ------------------------------
    // Widths and cache geometry
    // ------------------------------
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_vector = 32'h3000_0000;

    localparam int line_words = 4;
    localparam int num_lines = 16;

    // Word offset, line index and byte offset inside a line
    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits = $clog2(num_lines);
    localparam int line_byte_bits = offset_bits + 2;
    localparam int tag_bits = xlen - index_bits - line_byte_bits;

    // All-zero word decodes as an illegal instruction in RISC-V
    localparam logic [xlen-1:0] illegal_inst = '0;

    // ------------------------------
    // Channel payloads
    // ------------------------------
    typedef struct packed {
        logic [xlen-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [xlen-1:0] inst;
    } fetch_rsp_t;

    typedef struct packed {
        logic [xlen-1:0] line_addr;
    } refill_req_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
    } mem_ar_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic            last;
        logic            err;
    } mem_r_t;

endpackage

// ==== src/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            flush,
    input  logic            ready,
    output logic            inst_valid,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] snpc,
    output logic [xlen-1:0] inst,
    output logic            ar_valid,
    input  logic            ar_ready,
    output mem_ar_t         ar,
    input  logic            r_valid,
    output logic            r_ready,
    input  mem_r_t          r
);

    // Fetch unit to cache
    logic       lookup_valid;
    logic       lookup_ready;
    fetch_req_t lookup_req;
    logic       rsp_valid;
    fetch_rsp_t rsp;

    // Cache to memory read port
    logic            refill_valid;
    logic            refill_ready;
    refill_req_t     refill_req;
    logic            word_valid;
    logic            word_last;
    logic [xlen-1:0] word_data;

    fetch_unit u_fetch_unit (
        .clock        (clock),
        .reset        (reset),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .ready        (ready),
        .inst_valid   (inst_valid),
        .pc           (pc),
        .snpc         (snpc),
        .inst         (inst),
        .lookup_valid (lookup_valid),
        .lookup_ready (lookup_ready),
        .lookup_req   (lookup_req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp)
    );

    icache u_icache (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .lookup_valid (lookup_valid),
        .lookup_ready (lookup_ready),
        .lookup_req   (lookup_req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .refill_valid (refill_valid),
        .refill_ready (refill_ready),
        .refill_req   (refill_req),
        .word_valid   (word_valid),
        .word_last    (word_last),
        .word_data    (word_data)
    );

    mem_read_port u_mem_read_port (
        .clock        (clock),
        .reset        (reset),
        .refill_valid (refill_valid),
        .refill_ready (refill_ready),
        .refill_req   (refill_req),
        .word_valid   (word_valid),
        .word_last    (word_last),
        .word_data    (word_data),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .ar           (ar),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .r            (r)
    );

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            ready,
    output logic            inst_valid,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] snpc,
    output logic [xlen-1:0] inst,
    output logic            lookup_valid,
    input  logic            lookup_ready,
    output fetch_req_t      lookup_req,
    input  logic            rsp_valid,
    input  fetch_rsp_t      rsp
);

    logic started;
    logic accept;

    // Decode takes the instruction
    assign accept = inst_valid && ready;

    assign snpc = pc + 32'd4;

    // Lookup address follows pc, which only moves on acceptance
    assign lookup_req.addr = pc;

    // ------------------------------
    // Program counter
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (accept) begin
            if (redirect) begin
                pc <= redirect_pc;
            end else begin
                pc <= snpc;
            end
        end
    end

    // ------------------------------
    // Lookup request flag
    // ------------------------------
    // First lookup goes out once reset is gone, later ones after each acceptance
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            started <= 1'b0;
            lookup_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (!started || accept) begin
                lookup_valid <= 1'b1;
            end else if (lookup_valid && lookup_ready) begin
                lookup_valid <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Instruction register to decode
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (rsp_valid) begin
            inst_valid <= 1'b1;
        end else if (accept) begin
            inst_valid <= 1'b0;
        end
    end

    // Held until the next response, so stable under back-pressure
    always_ff @(posedge clock) begin
        if (rsp_valid) begin
            inst <= rsp.inst;
        end
    end

endmodule

// ==== src/icache.sv ====
`timescale 1ns/1ns

module icache
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            flush,
    input  logic            lookup_valid,
    output logic            lookup_ready,
    input  fetch_req_t      lookup_req,
    output logic            rsp_valid,
    output fetch_rsp_t      rsp,
    output logic            refill_valid,
    input  logic            refill_ready,
    output refill_req_t     refill_req,
    input  logic            word_valid,
    input  logic            word_last,
    input  logic [xlen-1:0] word_data
);

    typedef enum logic [1:0] {
        s_idle,
        s_request,
        s_fill,
        s_respond
    } state_t;

    state_t state;

    // Storage
    logic [num_lines-1:0] valid_bits;
    logic [tag_bits-1:0]  tag_array [num_lines];
    logic [xlen-1:0]      data_array [num_lines*line_words];

    logic                   flush_pending;
    logic [xlen-1:0]        req_addr;
    logic [offset_bits-1:0] beat;

    logic [tag_bits-1:0]    lookup_tag;
    logic [index_bits-1:0]  lookup_index;
    logic [offset_bits-1:0] lookup_offset;
    logic [tag_bits-1:0]    req_tag;
    logic [index_bits-1:0]  req_index;
    logic [offset_bits-1:0] req_offset;

    logic hit;
    logic accept;
    logic refilling;
    logic fill_done;

    // ------------------------------
    // Address split and hit check
    // ------------------------------
    assign lookup_tag    = lookup_req.addr[xlen-1 -: tag_bits];
    assign lookup_index  = lookup_req.addr[line_byte_bits +: index_bits];
    assign lookup_offset = lookup_req.addr[2 +: offset_bits];

    assign req_tag    = req_addr[xlen-1 -: tag_bits];
    assign req_index  = req_addr[line_byte_bits +: index_bits];
    assign req_offset = req_addr[2 +: offset_bits];

    assign hit = valid_bits[lookup_index] && (tag_array[lookup_index] == lookup_tag);

    assign lookup_ready = (state == s_idle);
    assign accept       = lookup_valid && lookup_ready;
    assign refilling    = (state == s_request) || (state == s_fill);
    assign fill_done    = (state == s_fill) && word_valid && word_last;

    assign refill_valid = (state == s_request);
    assign refill_req.line_addr = {req_addr[xlen-1:line_byte_bits], {line_byte_bits{1'b0}}};

    // ------------------------------
    // Refill FSM
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= s_idle;
            beat <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (accept && !hit) begin
                        state <= s_request;
                    end
                end
                s_request: begin
                    if (refill_ready) begin
                        state <= s_fill;
                        beat <= '0;
                    end
                end
                s_fill: begin
                    if (word_valid) begin
                        beat <= beat + 1'b1;
                        if (word_last) begin
                            state <= s_respond;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Valid bits and flush; a flush during refill waits for the last word
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
            flush_pending <= 1'b0;
        end else if (fill_done) begin
            if (flush_pending || flush) begin
                valid_bits <= '0;
            end else begin
                valid_bits[req_index] <= 1'b1;
            end
            flush_pending <= 1'b0;
        end else if (flush) begin
            if (refilling) begin
                flush_pending <= 1'b1;
            end else begin
                valid_bits <= '0;
            end
        end
    end

    // Tag and data arrays, plus the captured miss address
    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr <= lookup_req.addr;
        end
        if ((state == s_fill) && word_valid) begin
            data_array[{req_index, beat}] <= word_data;
        end
        if (fill_done) begin
            tag_array[req_index] <= req_tag;
        end
    end

    // ------------------------------
    // Response
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (accept && hit) || (state == s_respond);
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rsp.inst <= data_array[{lookup_index, lookup_offset}];
        end else if (state == s_respond) begin
            rsp.inst <= data_array[{req_index, req_offset}];
        end
    end

endmodule

// ==== src/mem_read_port.sv ====
`timescale 1ns/1ns

module mem_read_port
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            refill_valid,
    output logic            refill_ready,
    input  refill_req_t     refill_req,
    output logic            word_valid,
    output logic            word_last,
    output logic [xlen-1:0] word_data,
    output logic            ar_valid,
    input  logic            ar_ready,
    output mem_ar_t         ar,
    input  logic            r_valid,
    output logic            r_ready,
    input  mem_r_t          r
);

    typedef enum logic [1:0] {
        s_idle,
        s_addr,
        s_data
    } state_t;

    state_t state;

    logic [offset_bits-1:0] beat;
    logic err_held;
    logic beat_fire;
    logic beat_err;

    assign refill_ready = (state == s_idle);
    assign ar_valid     = (state == s_addr);
    assign r_ready      = (state == s_data);

    assign beat_fire = r_valid && r_ready;

    // Burst length comes from the counter and memory last is only checked
    assign word_valid = beat_fire;
    assign word_last  = (beat == offset_bits'(line_words - 1));
    assign beat_err   = r.err || (r.last != word_last);

    // Once a beat goes bad the rest of the line reads as illegal
    assign word_data = (err_held || beat_err) ? illegal_inst : r.data;

    // ------------------------------
    // Burst control
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= s_idle;
            beat <= '0;
            err_held <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (refill_valid) begin
                        state <= s_addr;
                    end
                end
                s_addr: begin
                    if (ar_ready) begin
                        state <= s_data;
                        beat <= '0;
                    end
                end
                s_data: begin
                    if (beat_fire) begin
                        beat <= beat + 1'b1;
                        if (word_last) begin
                            state <= s_idle;
                            err_held <= 1'b0;
                        end else begin
                            err_held <= err_held || beat_err;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Line address stays stable for the whole address phase
    always_ff @(posedge clock) begin
        if (refill_valid && refill_ready) begin
            ar.addr <= refill_req.line_addr;
        end
    end

endmodule

// ==== verification/fetch_assertions.sv ====
`timescale 1ns/1ns

module fetch_assertions
    import fetch_pkg::*;
(
    input logic            clock,
    input logic            reset,
    input logic            inst_valid,
    input logic            ready,
    input logic [xlen-1:0] pc,
    input logic [xlen-1:0] inst,
    input logic            ar_valid,
    input logic            ar_ready,
    input mem_ar_t         ar
);

    // Count of failed properties
    int fail_count = 0;

    // ------------------------------
    // Memory read address channel
    // ------------------------------
    ar_held: assert property (@(posedge clock) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            fail_count = fail_count + 1;
            $error("ar request dropped or changed before ar_ready");
        end

    // ------------------------------
    // Decode side
    // ------------------------------
    inst_held: assert property (@(posedge clock) disable iff (reset)
        inst_valid && !ready |=> inst_valid && $stable(pc) && $stable(inst))
        else begin
            fail_count = fail_count + 1;
            $error("pc or inst changed while decode stalled");
        end

    // Nothing offered to decode during reset
    quiet_in_reset: assert property (@(posedge clock) reset |-> !inst_valid)
        else begin
            fail_count = fail_count + 1;
            $error("inst_valid high while reset is active");
        end

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .ready      (ready),
    .pc         (pc),
    .inst       (inst),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar         (ar)
);

// ==== verification/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb
    import fetch_pkg::*;
();

    // One row of the stimulus table
    typedef struct packed {
        logic [7:0]      accepts;
        logic            redirect_on;
        logic [xlen-1:0] target;
        logic            flush_on;
        logic [7:0]      stall;
        logic [7:0]      exp_ar;
    } row_t;

    typedef enum logic [1:0] {
        mem_idle,
        mem_wait,
        mem_addr,
        mem_data
    } mem_state_t;

    logic            clock = 1'b0;
    logic            reset;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    logic            flush;
    logic            ready;
    logic            inst_valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] snpc;
    logic [xlen-1:0] inst;
    logic            ar_valid;
    logic            ar_ready = 1'b0;
    mem_ar_t         ar;
    logic            r_valid = 1'b0;
    logic            r_ready;
    mem_r_t          r = '0;

    row_t rows [7];

    // Memory model state
    mem_state_t      mem_state = mem_idle;
    logic [31:0]     seed = 32'h3c9e_09fe;
    int              delay_left = 0;
    int              beat_idx = 0;
    logic [xlen-1:0] burst_addr = '0;

    // Bus monitor
    int              ar_count = 0;
    logic [xlen-1:0] last_ar_addr = '0;
    logic            r_taken = 1'b0;

    fetch_top DUT (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .ready       (ready),
        .inst_valid  (inst_valid),
        .pc          (pc),
        .snpc        (snpc),
        .inst        (inst),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar          (ar),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r)
    );

    always #5 clock = ~clock;

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic row_t make_row(input int accepts, input logic redirect_on,
                                      input logic [xlen-1:0] target, input logic flush_on,
                                      input int stall, input int exp_ar);
        row_t row;
        row.accepts = 8'(accepts);
        row.redirect_on = redirect_on;
        row.target = target;
        row.flush_on = flush_on;
        row.stall = 8'(stall);
        row.exp_ar = 8'(exp_ar);
        return row;
    endfunction

    // Each memory word is its address XOR a fixed key
    function automatic mem_r_t make_beat(input logic [xlen-1:0] base, input int idx);
        mem_r_t beat;
        beat.data = (base + 32'(idx * 4)) ^ 32'h5a5a_0000;
        beat.last = (idx == line_words - 1);
        beat.err = 1'b0;
        return beat;
    endfunction

    task automatic wait_inst_valid();
        int cycles;
        cycles = 0;
        while (!inst_valid) begin
            @(negedge clock);
            cycles++;
            if (cycles > 100) begin
                $display("Timed out waiting for inst_valid from the fetch unit");
                abort_run();
            end
        end
    endtask

    task automatic check_outputs(input logic [xlen-1:0] exp_pc);
        assert (pc == exp_pc) else begin
            $display("Error: pc = %h, expected %h", pc, exp_pc);
            abort_run();
        end
        assert (snpc == exp_pc + 32'd4) else begin
            $display("Error: snpc = %h, expected %h", snpc, exp_pc + 32'd4);
            abort_run();
        end
        assert (inst == (exp_pc ^ 32'h5a5a_0000)) else begin
            $display("Error: inst = %h, expected %h", inst, exp_pc ^ 32'h5a5a_0000);
            abort_run();
        end
    endtask

    // Decode holds ready low and the outputs must not move
    task automatic hold_stall(input int cycles, input logic [xlen-1:0] exp_pc);
        int ar_before;
        ar_before = ar_count;
        repeat (cycles) begin
            @(negedge clock);
            assert (inst_valid) else begin
                $display("Error: inst_valid = %h during stall, expected 1", inst_valid);
                abort_run();
            end
            check_outputs(exp_pc);
            assert (ar_count == ar_before) else begin
                $display("Error: ar_count = %h during stall, expected %h", ar_count, ar_before);
                abort_run();
            end
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
    endtask

    task automatic accept_inst(input logic take_redirect, input logic [xlen-1:0] target);
        ready = 1'b1;
        redirect = take_redirect;
        redirect_pc = target;
        @(negedge clock);
        ready = 1'b0;
        redirect = 1'b0;
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    always @(negedge clock) begin
        if (reset) begin
            mem_state = mem_idle;
            ar_ready = 1'b0;
            r_valid = 1'b0;
        end else begin
            case (mem_state)
                mem_idle: begin
                    if (ar_valid) begin
                        burst_addr = ar.addr;
                        seed = next_random(seed);
                        delay_left = int'(seed % 4);
                        if (delay_left == 0) begin
                            ar_ready = 1'b1;
                            mem_state = mem_addr;
                        end else begin
                            mem_state = mem_wait;
                        end
                    end
                end
                mem_wait: begin
                    delay_left--;
                    if (delay_left == 0) begin
                        ar_ready = 1'b1;
                        mem_state = mem_addr;
                    end
                end
                // Address taken at the last rising edge
                mem_addr: begin
                    ar_ready = 1'b0;
                    beat_idx = 0;
                    r_valid = 1'b1;
                    r = make_beat(burst_addr, beat_idx);
                    mem_state = mem_data;
                end
                default: begin
                    if (r_taken) begin
                        beat_idx++;
                        if (beat_idx == line_words) begin
                            r_valid = 1'b0;
                            mem_state = mem_idle;
                        end else begin
                            r = make_beat(burst_addr, beat_idx);
                        end
                    end
                end
            endcase
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            r_taken <= 1'b0;
        end else begin
            r_taken <= r_valid && r_ready;
            if (ar_valid && ar_ready) begin
                ar_count <= ar_count + 1;
                last_ar_addr <= ar.addr;
                assert (ar.addr % (line_words * 4) == 0) else begin
                    $display("Error: ar.addr = %h, not line aligned", ar.addr);
                    abort_run();
                end
            end
        end
    end

    // Bound handshake checker
    always @(DUT.u_fetch_assertions.fail_count) begin
        assert (DUT.u_fetch_assertions.fail_count == 0) else begin
            $display("A handshake assertion bound to the DUT failed");
            abort_run();
        end
    end

    // ------------------------------
    // Stimulus table and main flow
    // ------------------------------
    initial begin
        row_t            row;
        logic [xlen-1:0] exp_pc;
        logic [xlen-1:0] row_pc;
        logic [xlen-1:0] line_mask;
        int              ar_base;
        logic            is_last;

        reset = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        flush = 1'b0;
        ready = 1'b0;
        line_mask = ~(32'(line_words * 4) - 32'd1);

        // Index wraps every num_lines lines, so + num_lines * line_words * 4 evicts
        rows[0] = make_row(8, 1'b1, reset_vector, 1'b0, 0, 2);
        rows[1] = make_row(8, 1'b1, reset_vector + num_lines * line_words * 4, 1'b0, 3, 0);
        rows[2] = make_row(4, 1'b1, reset_vector, 1'b0, 0, 1);
        rows[3] = make_row(8, 1'b1, reset_vector, 1'b0, 0, 1);
        rows[4] = make_row(4, 1'b0, '0, 1'b1, 0, 1);
        rows[5] = make_row(12, 1'b1, reset_vector + 16 * num_lines * line_words * 4 + 4,
                           1'b0, 2, 3);
        rows[6] = make_row(6, 1'b0, '0, 1'b0, 4, 2);

        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        exp_pc = reset_vector;
        ar_base = 0;
        for (int i = 0; i < $size(rows); i++) begin
            row = rows[i];
            row_pc = exp_pc;
            for (int k = 0; k < row.accepts; k++) begin
                is_last = (k == row.accepts - 1);
                wait_inst_valid();
                check_outputs(exp_pc);
                if (k == 0 && row.flush_on) begin
                    pulse_flush();
                end
                if (k == 0) begin
                    hold_stall(row.stall, exp_pc);
                end
                if (is_last) begin
                    assert (ar_count - ar_base == row.exp_ar) else begin
                        $display("Error: ar_count = %h in row %0d, expected %h",
                                 ar_count - ar_base, i, row.exp_ar);
                        abort_run();
                    end
                    ar_base = ar_count;
                    if (row.flush_on) begin
                        assert (last_ar_addr == (row_pc & line_mask)) else begin
                            $display("Error: ar.addr = %h after flush, expected %h",
                                     last_ar_addr, row_pc & line_mask);
                            abort_run();
                        end
                    end
                end
                accept_inst(is_last && row.redirect_on, row.target);
                if (is_last && row.redirect_on) begin
                    exp_pc = row.target;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
